// File: rtl/mcu_cfg_pkg.sv
// MCU-wide sizes, register map and core interrupt vector layout.
// Imported by the power manager, its register block and the interrupt path.
package mcu_cfg_pkg;

  // memory banks behind their own power switches
  localparam int unsigned NUM_BANKS = 6;

  localparam int unsigned XLEN = 32;
  localparam int unsigned REG_ADDR_W = 2;

  // power control register map
  localparam logic [REG_ADDR_W-1:0] ADDR_DOMAIN = 2'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_BANKS = 2'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_WAKE_MASK = 2'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS = 2'd3;

  // positions in the core interrupt vector
  localparam int unsigned IRQ_SW_BIT = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXT_BIT = 11;
  localparam int unsigned IRQ_FAST_LSB = 16;
  localparam int unsigned NUM_FAST = 15;

  // raw interrupt sources, before synchronization
  typedef struct packed {
    logic       sw;
    logic       ext;
    logic [3:0] timer;
    logic       dma_done;
    logic       spi;
    logic       spi_flash;
    logic [7:0] gpio_ao;
  } irq_src_t;

endpackage

// File: rtl/pwr_pkg.sv
// Power-control types shared by the register block and the domain sequencers.
// Holds the switch/isolation/reset bundle, sequencer states and command words.
package pwr_pkg;

  // all active low, all ones means powered and running
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

  typedef enum logic [3:0] {
    ST_ON,
    ST_CLK_OFF,
    ST_ISO_ON,
    ST_RST_ON,
    ST_SW_OFF,
    ST_OFF,
    ST_RET,
    ST_SW_ON,
    ST_RST_OFF,
    ST_ISO_OFF
  } pwr_state_e;

  // word at the domain register
  typedef struct packed {
    logic [29:0] rsvd;
    logic        periph_off;
    logic        cpu_sleep_pd_en;
  } pwr_domain_cmd_t;

  // word at the bank register
  typedef struct packed {
    logic [17:0] rsvd_hi;
    logic [5:0]  bank_ret;
    logic [1:0]  rsvd_lo;
    logic [5:0]  bank_off;
  } pwr_banks_cmd_t;

  typedef union packed {
    pwr_domain_cmd_t domain;
    pwr_banks_cmd_t  banks;
  } pwr_cmd_u;

endpackage

// File: rtl/irq_vector_sync.sv
// Synchronizes the raw interrupt sources and lays them out as the core
// interrupt vector. The vector lags the sources by two clock cycles.
`timescale 1ns/100ps

module irq_vector_sync
  import mcu_cfg_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  irq_src_t        irq_src_i,
  output logic [XLEN-1:0] intr_o
);

  irq_src_t            src_meta_q;
  irq_src_t            src_sync_q;
  logic [NUM_FAST-1:0] fast_intr;
  logic [XLEN-1:0]     intr;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_meta_q <= '0;
      src_sync_q <= '0;
    end else begin
      src_meta_q <= irq_src_i;
      src_sync_q <= src_meta_q;
    end
  end

  // fast lines, top one unused
  assign fast_intr = {
    1'b0,
    src_sync_q.gpio_ao,
    src_sync_q.spi_flash,
    src_sync_q.spi,
    src_sync_q.dma_done,
    src_sync_q.timer[3],
    src_sync_q.timer[2],
    src_sync_q.timer[1]
  };

  always_comb begin
    intr = '0;
    intr[IRQ_SW_BIT] = src_sync_q.sw;
    intr[IRQ_TIMER_BIT] = src_sync_q.timer[0];
    intr[IRQ_EXT_BIT] = src_sync_q.ext;
    intr[IRQ_FAST_LSB+:NUM_FAST] = fast_intr;
  end

  assign intr_o = intr;

endmodule

// File: rtl/pwr_ctrl_regs.sv
// Power configuration registers written by a plain strobe.
// Turns the stored settings into off/retention requests for the sequencers.
`timescale 1ns/100ps

module pwr_ctrl_regs
  import mcu_cfg_pkg::*;
  import pwr_pkg::*;
#(
  parameter int unsigned NUM_BANKS = mcu_cfg_pkg::NUM_BANKS
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  reg_wr_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [XLEN-1:0]       reg_wdata_i,
  input  logic [XLEN-1:0]       intr_i,
  input  logic                  core_sleep_i,
  input  logic [NUM_BANKS+1:0]  dom_on_i,
  output logic [XLEN-1:0]       reg_rdata_o,
  output logic                  cpu_off_req_o,
  output logic                  periph_off_req_o,
  output logic [NUM_BANKS-1:0]  bank_off_req_o,
  output logic [NUM_BANKS-1:0]  bank_ret_o
);

  pwr_cmd_u             wr_cmd;
  pwr_cmd_u             rd_cmd;
  logic                 cpu_sleep_pd_en_q;
  logic                 periph_off_q;
  logic [NUM_BANKS-1:0] bank_off_q;
  logic [NUM_BANKS-1:0] bank_ret_q;
  logic [XLEN-1:0]      wake_mask_q;
  logic                 wake_pending;

  assign wr_cmd = reg_wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cpu_sleep_pd_en_q <= 1'b0;
      periph_off_q      <= 1'b0;
      bank_off_q        <= '0;
      bank_ret_q        <= '0;
      wake_mask_q       <= '0;
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        ADDR_DOMAIN: begin
          cpu_sleep_pd_en_q <= wr_cmd.domain.cpu_sleep_pd_en;
          periph_off_q      <= wr_cmd.domain.periph_off;
        end
        ADDR_BANKS: begin
          bank_off_q <= wr_cmd.banks.bank_off[NUM_BANKS-1:0];
          bank_ret_q <= wr_cmd.banks.bank_ret[NUM_BANKS-1:0];
        end
        ADDR_WAKE_MASK: wake_mask_q <= reg_wdata_i;
        // status is read only
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_cmd = '0;
    case (reg_addr_i)
      ADDR_DOMAIN: begin
        rd_cmd.domain.cpu_sleep_pd_en = cpu_sleep_pd_en_q;
        rd_cmd.domain.periph_off      = periph_off_q;
      end
      ADDR_BANKS: begin
        rd_cmd.banks.bank_off[NUM_BANKS-1:0] = bank_off_q;
        rd_cmd.banks.bank_ret[NUM_BANKS-1:0] = bank_ret_q;
      end
      ADDR_WAKE_MASK: rd_cmd = wake_mask_q;
      ADDR_STATUS:    rd_cmd = XLEN'(dom_on_i);
      default: ;
    endcase
  end

  assign reg_rdata_o = rd_cmd;

  // cpu goes down only while asleep with nothing to wake it
  assign wake_pending  = |(intr_i & wake_mask_q);
  assign cpu_off_req_o = cpu_sleep_pd_en_q & core_sleep_i & ~wake_pending;

  assign periph_off_req_o = periph_off_q;
  assign bank_off_req_o   = bank_off_q;
  assign bank_ret_o       = bank_ret_q;

  // a mask written over a pending source keeps the cpu request low
  a_no_sleep_on_wake: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (reg_wr_i && reg_addr_i == ADDR_WAKE_MASK && (intr_i & reg_wdata_i) != '0)
      |=> (!cpu_off_req_o || !$stable(intr_i))
  ) else $error("cpu power-down requested with a masked interrupt pending");

endmodule

// File: rtl/pwr_domain_seq.sv
// Power-down and power-up sequencer for one switchable domain.
// Steps clock gate, isolation, reset and switch; banks may also park in retention.
`timescale 1ns/100ps

module pwr_domain_seq
  import pwr_pkg::*;
#(
  parameter bit HAS_RETENTION = 1'b0
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          off_req_i,
  input  logic          ret_mode_i,
  input  logic          pwrgate_ack_ni,
  output pwr_ctrl_out_t pwr_o,
  output logic          is_on_o
);

  pwr_state_e    state_q;
  pwr_state_e    state_d;
  pwr_ctrl_out_t pwr_d;
  pwr_ctrl_out_t pwr_q;
  logic          ret_req;
  logic          ret_q;
  logic          is_on_q;

  assign ret_req = HAS_RETENTION && ret_mode_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_ON: begin
        if (off_req_i)
          state_d = ST_CLK_OFF;
      end
      // retention choice was taken when leaving ST_ON
      ST_CLK_OFF: state_d = ret_q ? ST_RET : ST_ISO_ON;
      ST_ISO_ON:  state_d = ST_RST_ON;
      ST_RST_ON:  state_d = ST_SW_OFF;
      ST_SW_OFF: begin
        if (!pwr_q.pwrgate_en_n && !pwrgate_ack_ni)
          state_d = ST_OFF;
      end
      // a retention request wakes the bank first, then parks it
      ST_OFF: begin
        if (!off_req_i || ret_req)
          state_d = ST_SW_ON;
      end
      ST_RET: begin
        if (!off_req_i)
          state_d = ST_ISO_OFF;
        else if (!ret_req)
          state_d = ST_ISO_ON;
      end
      ST_SW_ON: begin
        if (pwr_q.pwrgate_en_n && pwrgate_ack_ni)
          state_d = ST_RST_OFF;
      end
      ST_RST_OFF: state_d = ST_ISO_OFF;
      ST_ISO_OFF: state_d = ST_ON;
      default:    state_d = ST_ON;
    endcase
  end

  // output pattern of each state
  always_comb begin
    pwr_d = '1;
    case (state_q)
      ST_CLK_OFF, ST_ISO_OFF: begin
        pwr_d.clkgate_en_n = 1'b0;
      end
      ST_ISO_ON, ST_RST_OFF: begin
        pwr_d.clkgate_en_n = 1'b0;
        pwr_d.isogate_en_n = 1'b0;
      end
      ST_RST_ON, ST_SW_ON: begin
        pwr_d.clkgate_en_n = 1'b0;
        pwr_d.isogate_en_n = 1'b0;
        pwr_d.rst_n        = 1'b0;
      end
      ST_SW_OFF, ST_OFF: begin
        pwr_d.clkgate_en_n = 1'b0;
        pwr_d.isogate_en_n = 1'b0;
        pwr_d.rst_n        = 1'b0;
        pwr_d.pwrgate_en_n = 1'b0;
      end
      ST_RET: begin
        pwr_d.clkgate_en_n   = 1'b0;
        pwr_d.retentive_en_n = 1'b0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_ON;
      ret_q   <= 1'b0;
      pwr_q   <= '1;
      is_on_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_q == ST_ON && off_req_i)
        ret_q <= ret_req;
      pwr_q   <= pwr_d;
      // status moves together with the registered outputs
      is_on_q <= (state_q == ST_ON);
    end
  end

  assign pwr_o   = pwr_q;
  assign is_on_o = is_on_q;

  a_iso_when_off: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !pwr_q.pwrgate_en_n |-> !pwr_q.isogate_en_n
  ) else $error("power switch open while isolation is released");

  a_clk_in_reset: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !pwr_q.rst_n |-> !pwr_q.clkgate_en_n
  ) else $error("domain clock running while held in reset");

endmodule

// File: rtl/mcu_power_manager.sv
// Always-on power manager of the MCU: register block, one sequencer per domain
// and the interrupt path that can wake the sleeping CPU.
`timescale 1ns/100ps

module mcu_power_manager
  import mcu_cfg_pkg::*;
  import pwr_pkg::*;
#(
  parameter int unsigned NUM_BANKS = mcu_cfg_pkg::NUM_BANKS
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  debug_reset_n_i,
  input  logic                  core_sleep_i,
  input  irq_src_t              irq_src_i,
  input  logic                  reg_wr_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [XLEN-1:0]       reg_wdata_i,
  input  logic                  cpu_ack_n_i,
  input  logic                  periph_ack_n_i,
  input  logic                  bank_ack_n_i [NUM_BANKS],
  output logic [XLEN-1:0]       intr_o,
  output logic [XLEN-1:0]       reg_rdata_o,
  output pwr_ctrl_out_t         cpu_pwr_o,
  output pwr_ctrl_out_t         periph_pwr_o,
  output pwr_ctrl_out_t         bank_pwr_o [NUM_BANKS],
  output logic                  cpu_rst_n_o,
  output logic                  periph_rst_n_o
);

  logic [XLEN-1:0]      intr;
  logic                 cpu_off_req;
  logic                 periph_off_req;
  logic [NUM_BANKS-1:0] bank_off_req;
  logic [NUM_BANKS-1:0] bank_ret;
  // cpu, peripheral, then banks from bit 2
  logic [NUM_BANKS+1:0] dom_on;

  irq_vector_sync i_irq_vector_sync (
    .clk_i,
    .arst_n_i,
    .irq_src_i,
    .intr_o(intr)
  );

  pwr_ctrl_regs #(
    .NUM_BANKS(NUM_BANKS)
  ) i_pwr_ctrl_regs (
    .clk_i,
    .arst_n_i,
    .reg_wr_i,
    .reg_addr_i,
    .reg_wdata_i,
    .intr_i(intr),
    .core_sleep_i,
    .dom_on_i(dom_on),
    .reg_rdata_o,
    .cpu_off_req_o(cpu_off_req),
    .periph_off_req_o(periph_off_req),
    .bank_off_req_o(bank_off_req),
    .bank_ret_o(bank_ret)
  );

  pwr_domain_seq #(
    .HAS_RETENTION(1'b0)
  ) i_cpu_seq (
    .clk_i,
    .arst_n_i,
    .off_req_i(cpu_off_req),
    .ret_mode_i(1'b0),
    .pwrgate_ack_ni(cpu_ack_n_i),
    .pwr_o(cpu_pwr_o),
    .is_on_o(dom_on[0])
  );

  pwr_domain_seq #(
    .HAS_RETENTION(1'b0)
  ) i_periph_seq (
    .clk_i,
    .arst_n_i,
    .off_req_i(periph_off_req),
    .ret_mode_i(1'b0),
    .pwrgate_ack_ni(periph_ack_n_i),
    .pwr_o(periph_pwr_o),
    .is_on_o(dom_on[1])
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    pwr_domain_seq #(
      .HAS_RETENTION(1'b1)
    ) i_bank_seq (
      .clk_i,
      .arst_n_i,
      .off_req_i(bank_off_req[b]),
      .ret_mode_i(bank_ret[b]),
      .pwrgate_ack_ni(bank_ack_n_i[b]),
      .pwr_o(bank_pwr_o[b]),
      .is_on_o(dom_on[b+2])
    );
  end

  assign intr_o = intr;

  // debug non-dm reset also holds both domains
  assign cpu_rst_n_o    = cpu_pwr_o.rst_n & debug_reset_n_i;
  assign periph_rst_n_o = periph_pwr_o.rst_n & debug_reset_n_i;

endmodule

// File: tests/tb_ref_model.svh
// Reference model of the power manager, included inside the testbench module.
// Expected interrupt vector, settled power patterns and register write tasks.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// settled states of a domain
localparam int MODE_ON = 0;
localparam int MODE_OFF = 1;
localparam int MODE_RET = 2;

function automatic logic [XLEN-1:0] exp_intr(irq_src_t s);
  logic [XLEN-1:0] v;
  v = '0;
  v[IRQ_SW_BIT] = s.sw;
  v[IRQ_TIMER_BIT] = s.timer[0];
  v[IRQ_EXT_BIT] = s.ext;
  // fast lines start with timers 1 to 3
  for (int i = 0; i < 3; i++)
    v[IRQ_FAST_LSB + i] = s.timer[i + 1];
  v[IRQ_FAST_LSB + 3] = s.dma_done;
  v[IRQ_FAST_LSB + 4] = s.spi;
  v[IRQ_FAST_LSB + 5] = s.spi_flash;
  for (int i = 0; i < 8; i++)
    v[IRQ_FAST_LSB + 6 + i] = s.gpio_ao[i];
  return v;
endfunction

function automatic pwr_ctrl_out_t expected_pwr(int mode);
  pwr_ctrl_out_t p;
  p = '1;
  if (mode == MODE_OFF) begin
    p.pwrgate_en_n = 1'b0;
    p.isogate_en_n = 1'b0;
    p.rst_n = 1'b0;
    p.clkgate_en_n = 1'b0;
  end else if (mode == MODE_RET) begin
    p.clkgate_en_n = 1'b0;
    p.retentive_en_n = 1'b0;
  end
  return p;
endfunction

// retention only matters while the bank is asked to go down
function automatic int bank_mode(logic off, logic ret);
  if (!off)
    return MODE_ON;
  return ret ? MODE_RET : MODE_OFF;
endfunction

task automatic write_reg(logic [REG_ADDR_W-1:0] addr, logic [XLEN-1:0] data);
  reg_wr = 1'b1;
  reg_addr = addr;
  reg_wdata = data;
  @(negedge clk);
  reg_wr = 1'b0;
  reg_addr = ADDR_STATUS;
  reg_wdata = '0;
endtask

task automatic write_domain(logic cpu_sleep_pd_en, logic periph_off);
  write_reg(ADDR_DOMAIN, XLEN'({periph_off, cpu_sleep_pd_en}));
endtask

task automatic write_banks(logic [NUM_BANKS-1:0] off, logic [NUM_BANKS-1:0] ret);
  write_reg(ADDR_BANKS, (XLEN'(ret) << 8) | XLEN'(off));
endtask

`endif

// File: tests/tb_mcu_power_manager.sv
// Testbench for the MCU power manager: random interrupts, domain and bank
// power sequences with modeled switch acknowledges, CPU sleep and debug reset.
`timescale 1ns/100ps

module tb_mcu_power_manager
  import mcu_cfg_pkg::*;
  import pwr_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_DOM = NUM_BANKS + 2;
  localparam int IRQ_STEPS = 200;
  localparam int BANK_ROUNDS = 4 * NUM_BANKS;
  // longest settle, a bank may pass through on before retention
  localparam int SEQ_CYCLES = 40;
  localparam int TEST_STEPS = IRQ_STEPS + BANK_ROUNDS + 16;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  debug_reset_n;
  logic                  core_sleep;
  irq_src_t              irq_src;
  logic                  reg_wr;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [XLEN-1:0]       reg_wdata;
  logic                  bank_ack_n [NUM_BANKS];
  logic [XLEN-1:0]       intr;
  logic [XLEN-1:0]       reg_rdata;
  pwr_ctrl_out_t         cpu_pwr;
  pwr_ctrl_out_t         periph_pwr;
  pwr_ctrl_out_t         bank_pwr [NUM_BANKS];
  logic                  cpu_rst_n;
  logic                  periph_rst_n;

  // acknowledges of cpu, peripheral, then banks
  logic          ack_n [NUM_DOM] = '{default: 1'b1};
  int            ack_wait [NUM_DOM] = '{default: 0};
  irq_src_t      src_hist [2] = '{default: '0};
  pwr_ctrl_out_t bank_snap [NUM_BANKS];
  int            watch_bank = -1;
  int            errors = 0;
  int            checks = 0;

  `include "tb_ref_model.svh"

  mcu_power_manager #(
    .NUM_BANKS(NUM_BANKS)
  ) i_mcu_power_manager (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .debug_reset_n_i(debug_reset_n),
    .core_sleep_i(core_sleep),
    .irq_src_i(irq_src),
    .reg_wr_i(reg_wr),
    .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata),
    .cpu_ack_n_i(ack_n[0]),
    .periph_ack_n_i(ack_n[1]),
    .bank_ack_n_i(bank_ack_n),
    .intr_o(intr),
    .reg_rdata_o(reg_rdata),
    .cpu_pwr_o(cpu_pwr),
    .periph_pwr_o(periph_pwr),
    .bank_pwr_o(bank_pwr),
    .cpu_rst_n_o(cpu_rst_n),
    .periph_rst_n_o(periph_rst_n)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_ack
    assign bank_ack_n[b] = ack_n[b + 2];
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic pwr_ctrl_out_t dom_pwr(int d);
    if (d == 0)
      return cpu_pwr;
    if (d == 1)
      return periph_pwr;
    return bank_pwr[d - 2];
  endfunction

  function automatic string dom_name(int d);
    if (d == 0)
      return "cpu_pwr_o";
    if (d == 1)
      return "periph_pwr_o";
    return $sformatf("bank_pwr_o[%0d]", d - 2);
  endfunction

  task automatic check_val(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t %s exp %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t %s exp %b got %b", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_pwr(string name, pwr_ctrl_out_t got, pwr_ctrl_out_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t %s exp %b got %b", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic wait_status(int idx, logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (reg_rdata[idx] !== level && n < SEQ_CYCLES);
    if (reg_rdata[idx] !== level) begin
      $display("status bit %0d did not reach %b within %0d cycles", idx, level, SEQ_CYCLES);
      errors++;
    end
  endtask

  // banks other than watch_bank must hold their snapshot meanwhile
  task automatic wait_pwr(int d, pwr_ctrl_out_t exp);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      for (int k = 0; k < NUM_BANKS; k++) begin
        if (watch_bank >= 0 && k != watch_bank)
          check_pwr(dom_name(k + 2), bank_pwr[k], bank_snap[k]);
      end
    end while (dom_pwr(d) !== exp && n < SEQ_CYCLES);
    check_pwr(dom_name(d), dom_pwr(d), exp);
  endtask

  // power switch model, acknowledge follows the enable after 1 to 8 cycles
  always @(negedge clk) begin
    pwr_ctrl_out_t p;
    for (int d = 0; d < NUM_DOM; d++) begin
      p = dom_pwr(d);
      if (p.pwrgate_en_n === ack_n[d]) begin
        ack_wait[d] = 0;
      end else if (ack_wait[d] == 0) begin
        ack_wait[d] = 1 + int'($urandom % 8);
      end else begin
        ack_wait[d]--;
        if (ack_wait[d] == 0)
          ack_n[d] = p.pwrgate_en_n;
      end
    end
  end

  // sources as sampled by the last two rising edges
  always @(posedge clk) begin
    src_hist[1] <= src_hist[0];
    src_hist[0] <= irq_src;
  end

  // the vector lags the sampled sources by two edges
  always @(negedge clk) begin
    if (arst_n) begin
      checks++;
      if (intr !== exp_intr(src_hist[1])) begin
        $display("[FAIL] %0t intr_o exp %h got %h", $time, exp_intr(src_hist[1]), intr);
        errors++;
      end
    end
  end

  initial begin
    #(TEST_STEPS * SEQ_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", TEST_STEPS * SEQ_CYCLES);
    $display("checks: %0d  errors: %0d", checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0]          rnd;
    logic [NUM_BANKS-1:0] bank_off;
    logic [NUM_BANKS-1:0] bank_ret;
    int                   b;
    int                   mode;
    arst_n = 1'b0;
    debug_reset_n = 1'b1;
    core_sleep = 1'b0;
    irq_src = '0;
    reg_wr = 1'b0;
    reg_addr = ADDR_STATUS;
    reg_wdata = '0;
    bank_off = '0;
    bank_ret = '0;
    void'($urandom(32'hde0f_5826));
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    @(negedge clk);
    for (int d = 0; d < NUM_DOM; d++)
      check_pwr(dom_name(d), dom_pwr(d), expected_pwr(MODE_ON));
    check_val("intr_o", intr, '0);
    check_val("status", reg_rdata, XLEN'((1 << NUM_DOM) - 1));
    for (int i = 0; i < IRQ_STEPS; i++) begin
      rnd = $urandom;
      irq_src = rnd[16:0];
      @(negedge clk);
    end
    irq_src = '0;
    repeat (3) @(negedge clk);

    // peripheral domain down and back up
    write_domain(1'b0, 1'b1);
    wait_status(1, 1'b0);
    wait_pwr(1, expected_pwr(MODE_OFF));
    write_domain(1'b0, 1'b0);
    wait_status(1, 1'b1);
    check_pwr("periph_pwr_o", periph_pwr, expected_pwr(MODE_ON));

    for (int r = 0; r < BANK_ROUNDS; r++) begin
      b = r % NUM_BANKS;
      rnd = $urandom;
      bank_off[b] = rnd[0];
      bank_ret[b] = rnd[1];
      for (int k = 0; k < NUM_BANKS; k++)
        bank_snap[k] = bank_pwr[k];
      watch_bank = b;
      write_banks(bank_off, bank_ret);
      mode = bank_mode(bank_off[b], bank_ret[b]);
      wait_pwr(b + 2, expected_pwr(mode));
      watch_bank = -1;
      check_bit($sformatf("status bit %0d", b + 2), reg_rdata[b + 2], mode == MODE_ON);
    end

    // dma done is the fourth fast line
    write_reg(ADDR_WAKE_MASK, XLEN'(1) << (IRQ_FAST_LSB + 3));
    write_domain(1'b1, 1'b0);
    core_sleep = 1'b1;
    wait_status(0, 1'b0);
    wait_pwr(0, expected_pwr(MODE_OFF));
    check_bit("cpu_rst_n_o", cpu_rst_n, 1'b0);
    irq_src.spi = 1'b1;
    repeat (16) @(negedge clk);
    check_bit("status bit 0", reg_rdata[0], 1'b0);
    check_pwr("cpu_pwr_o", cpu_pwr, expected_pwr(MODE_OFF));
    irq_src.spi = 1'b0;
    irq_src.dma_done = 1'b1;
    wait_status(0, 1'b1);
    check_pwr("cpu_pwr_o", cpu_pwr, expected_pwr(MODE_ON));
    core_sleep = 1'b0;
    irq_src.dma_done = 1'b0;
    write_domain(1'b0, 1'b0);

    check_bit("cpu_pwr_o.rst_n", cpu_pwr.rst_n, 1'b1);
    debug_reset_n = 1'b0;
    @(negedge clk);
    check_bit("cpu_rst_n_o", cpu_rst_n, 1'b0);
    check_bit("periph_rst_n_o", periph_rst_n, 1'b0);
    debug_reset_n = 1'b1;
    @(negedge clk);
    check_bit("cpu_rst_n_o", cpu_rst_n, 1'b1);
    check_bit("periph_rst_n_o", periph_rst_n, 1'b1);

    repeat (2) @(negedge clk);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: mcu_power_manager.f
+incdir+tests
rtl/mcu_cfg_pkg.sv
rtl/pwr_pkg.sv
rtl/irq_vector_sync.sv
rtl/pwr_ctrl_regs.sv
rtl/pwr_domain_seq.sv
rtl/mcu_power_manager.sv
tests/tb_mcu_power_manager.sv

// File: run_sim.sh
#!/bin/sh
# Builds the power manager testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f mcu_power_manager.f \
  --top-module tb_mcu_power_manager \
  -Mdir obj_dir

./obj_dir/Vtb_mcu_power_manager | tee "$LOG"

if grep -q "PASS: all tests" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi
